// File: cluster_bus.f
+incdir+design
design/cluster_bus_pkg.sv
design/cluster_addr_decoder.sv
design/cluster_bus_arbiter.sv
design/cluster_resp_router.sv
design/cluster_bus_top.sv
verification/cluster_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cluster bus testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f cluster_bus.f \
    --top-module cluster_bus_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vcluster_bus_tb; then
  echo "Simulation failed"
  exit 1
fi

exit 0

// File: verification/cluster_bus_tb.sv
/* Cluster bus testbench
   LFSR-driven traffic from four initiators with responding targets,
   checked against per-pair queues of expected requests and responses */

`default_nettype none

`include "cluster_bus_macros.svh"

module cluster_bus_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cluster_bus_pkg::*;

  localparam int          NB_REQ     = 400;
  localparam int          MAX_CYCLE  = 20 * NB_REQ;
  localparam int          RR_OUTS    = 16;
  localparam logic [31:0] RDATA_MASK = 32'hA5A5_A5A5;

  logic                        clk;
  logic                        arst_n;
  cluster_id_t                 cluster_id;
  init_req_t [`CB_NB_INIT-1:0] init_req;
  logic      [`CB_NB_INIT-1:0] init_valid;
  logic      [`CB_NB_INIT-1:0] init_ready;
  targ_req_t [`CB_NB_TARG-1:0] targ_req;
  logic      [`CB_NB_TARG-1:0] targ_valid;
  logic      [`CB_NB_TARG-1:0] targ_ready;
  targ_rsp_t [`CB_NB_TARG-1:0] targ_rsp;
  logic      [`CB_NB_TARG-1:0] targ_rsp_valid;
  logic      [`CB_NB_TARG-1:0] targ_rsp_ready;
  init_rsp_t [`CB_NB_INIT-1:0] init_rsp;
  logic      [`CB_NB_INIT-1:0] init_rsp_valid;
  logic      [`CB_NB_INIT-1:0] init_rsp_ready;

  logic [15:0]            lfsr;
  int                     gen_cnt;
  int                     rsp_cnt;
  int                     cycle_cnt;
  int                     tcdm_out_cnt;
  int                     leftover;
  logic [`CB_NB_INIT-1:0] req_done;
  logic [`CB_NB_TARG-1:0] rsp_done;

  // Model state per initiator and target pair, and per target responder
  targ_req_t exp_req  [`CB_NB_INIT][`CB_NB_TARG][$];
  targ_rsp_t held_rsp [`CB_NB_TARG][$];
  init_rsp_t exp_rsp  [`CB_NB_INIT][$];

  cluster_bus_top dut0 (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .cluster_id_i     ( cluster_id     ),
    .init_req_i       ( init_req       ),
    .init_valid_i     ( init_valid     ),
    .init_ready_o     ( init_ready     ),
    .targ_req_o       ( targ_req       ),
    .targ_valid_o     ( targ_valid     ),
    .targ_ready_i     ( targ_ready     ),
    .targ_rsp_i       ( targ_rsp       ),
    .targ_rsp_valid_i ( targ_rsp_valid ),
    .targ_rsp_ready_o ( targ_rsp_ready ),
    .init_rsp_o       ( init_rsp       ),
    .init_rsp_valid_o ( init_rsp_valid ),
    .init_rsp_ready_i ( init_rsp_ready )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR with taps 16, 14, 13, 11, one step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int b = 0; b < nbits; b++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int map_target(input addr_t addr);
    addr_t offset;
    offset = {4'd0, cluster_id, 22'd0};
    if (addr >= `CB_TCDM_START + offset && addr <= `CB_TCDM_END + offset) begin
      return `CB_TARG_TCDM;
    end
    if (addr >= `CB_PERIPH_START + offset && addr <= `CB_PERIPH_END + offset) begin
      return `CB_TARG_PERIPH;
    end
    return `CB_TARG_EXT;
  endfunction

  // Addresses land in the shifted windows, anywhere, or in the unshifted tcdm window
  function automatic addr_t pick_addr(input logic force_tcdm);
    logic [1:0] kind;
    addr_t      offset;
    offset = {4'd0, cluster_id, 22'd0};
    kind   = force_tcdm ? 2'd0 : 2'(rand_bits(2));
    case (kind)
      2'd0:    return `CB_TCDM_START + offset + rand_bits(20);
      2'd1:    return `CB_PERIPH_START + offset + rand_bits(21);
      2'd2:    return rand_bits(32);
      default: return `CB_TCDM_START + rand_bits(20);
    endcase
  endfunction

  task stop_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task check_value(input string name, input logic [127:0] expected, input logic [127:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      stop_run();
    end
  endtask

  task drive_inputs();
    logic rr_phase;
    rr_phase = (tcdm_out_cnt < RR_OUTS);
    for (int i = 0; i < `CB_NB_INIT; i++) begin
      if (req_done[i]) init_valid[i] = 1'b0;
      if (!init_valid[i] && gen_cnt < NB_REQ && (rr_phase || rand_bits(1) == 32'd1)) begin
        init_req[i].addr  = pick_addr(rr_phase);
        init_req[i].wdata = rand_bits(32);
        init_req[i].we    = 1'(rand_bits(1));
        init_req[i].id_in = id_in_t'(rand_bits(4));
        init_valid[i]     = 1'b1;
        gen_cnt++;
      end
    end
    targ_ready = rr_phase ? '1 : 3'(rand_bits(3));
    for (int t = 0; t < `CB_NB_TARG; t++) begin
      if (rsp_done[t]) targ_rsp_valid[t] = 1'b0;
      if (!targ_rsp_valid[t] && held_rsp[t].size() > 0 && rand_bits(2) != 32'd0) begin
        targ_rsp[t]       = held_rsp[t][0];
        targ_rsp_valid[t] = 1'b1;
      end
    end
    init_rsp_ready = 4'(rand_bits(4)) | 4'(rand_bits(4));
    req_done       = '0;
    rsp_done       = '0;
  endtask

  task sample_outputs();
    targ_req_t req;
    targ_rsp_t rsp;
    init_rsp_t exp;
    int        src;
    int        dst;
    for (int i = 0; i < `CB_NB_INIT; i++) begin
      if (init_valid[i] && init_ready[i]) begin
        dst        = map_target(init_req[i].addr);
        req.addr   = init_req[i].addr;
        req.wdata  = init_req[i].wdata;
        req.we     = init_req[i].we;
        req.id_out = {init_idx_t'(i), init_req[i].id_in};
        exp_req[i][dst].push_back(req);
        req_done[i] = 1'b1;
      end
    end
    for (int t = 0; t < `CB_NB_TARG; t++) begin
      if (targ_valid[t] && targ_ready[t]) begin
        src = int'(targ_req[t].id_out[`CB_ID_OUT_W-1 -: `CB_INIT_IDX_W]);
        if (t == `CB_TARG_TCDM && tcdm_out_cnt < RR_OUTS) begin
          check_value("round_robin", 128'(tcdm_out_cnt % 4), 128'(src));
        end
        if (t == `CB_TARG_TCDM) tcdm_out_cnt++;
        if (exp_req[src][t].size() == 0) begin
          $display("Target %0d received a request from initiator %0d that was never sent there",
                   t, src);
          stop_run();
        end
        req = exp_req[src][t].pop_front();
        check_value("target_request", 128'(req), 128'(targ_req[t]));
        rsp.rdata  = req.addr ^ RDATA_MASK;
        rsp.id_out = req.id_out;
        held_rsp[t].push_back(rsp);
      end
    end
    // The router has no latency, so a target handshake pairs with an initiator one
    for (int t = 0; t < `CB_NB_TARG; t++) begin
      if (targ_rsp_valid[t] && targ_rsp_ready[t]) begin
        rsp       = held_rsp[t].pop_front();
        dst       = int'(rsp.id_out[`CB_ID_OUT_W-1 -: `CB_INIT_IDX_W]);
        // A lower target with a response for the same initiator has to win
        for (int u = 0; u < t; u++) begin
          if (targ_rsp_valid[u] &&
              int'(targ_rsp[u].id_out[`CB_ID_OUT_W-1 -: `CB_INIT_IDX_W]) == dst) begin
            $display("Target %0d was served for initiator %0d before lower target %0d",
                     t, dst, u);
            stop_run();
          end
        end
        exp.rdata = rsp.rdata;
        exp.id_in = rsp.id_out[`CB_ID_IN_W-1:0];
        exp_rsp[dst].push_back(exp);
        rsp_done[t] = 1'b1;
      end
    end
    for (int i = 0; i < `CB_NB_INIT; i++) begin
      if (init_rsp_valid[i] && init_rsp_ready[i]) begin
        if (exp_rsp[i].size() == 0) begin
          $display("Initiator %0d received a response that no target sent", i);
          stop_run();
        end
        exp = exp_rsp[i].pop_front();
        check_value("initiator_response", 128'(exp), 128'(init_rsp[i]));
        rsp_cnt++;
      end
      if (exp_rsp[i].size() != 0) begin
        $display("A response for initiator %0d left its target but never arrived", i);
        stop_run();
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLE) begin
      $display("Timeout after %0d cycles with %0d of %0d responses seen",
               cycle_cnt, rsp_cnt, NB_REQ);
      stop_run();
    end
  end

  initial begin
    lfsr           = 16'd6;
    cluster_id     = 6'd5;
    arst_n         = 1'b0;
    init_req       = '0;
    init_valid     = '0;
    targ_ready     = '0;
    targ_rsp       = '0;
    targ_rsp_valid = '0;
    init_rsp_ready = '0;
    req_done       = '0;
    rsp_done       = '0;
    gen_cnt        = 0;
    rsp_cnt        = 0;
    cycle_cnt      = 0;
    tcdm_out_cnt   = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    while (rsp_cnt < NB_REQ) begin
      drive_inputs();
      @(negedge clk);
      sample_outputs();
      @(posedge clk);
      #1;
    end
    // Every request has been answered, so no target port may still hold one
    leftover = 0;
    for (int t = 0; t < `CB_NB_TARG; t++) begin
      leftover += held_rsp[t].size();
      leftover += int'(targ_valid[t]);
      for (int i = 0; i < `CB_NB_INIT; i++) leftover += exp_req[i][t].size();
    end
    if (leftover == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("%0d requests are still pending in the model or on a target port at the end",
               leftover);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// File: design/cluster_bus_top.sv
/* Cluster bus
   Crossbar from the ext, dma, data and instr initiators to the tcdm,
   periph and ext targets, single-beat requests with ID-routed responses */

`default_nettype none

`include "cluster_bus_macros.svh"

module cluster_bus_top (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  cluster_bus_pkg::cluster_id_t                cluster_id_i,
  input  cluster_bus_pkg::init_req_t [`CB_NB_INIT-1:0] init_req_i,
  input  logic                      [`CB_NB_INIT-1:0] init_valid_i,
  output logic                      [`CB_NB_INIT-1:0] init_ready_o,
  output cluster_bus_pkg::targ_req_t [`CB_NB_TARG-1:0] targ_req_o,
  output logic                      [`CB_NB_TARG-1:0] targ_valid_o,
  input  logic                      [`CB_NB_TARG-1:0] targ_ready_i,
  input  cluster_bus_pkg::targ_rsp_t [`CB_NB_TARG-1:0] targ_rsp_i,
  input  logic                      [`CB_NB_TARG-1:0] targ_rsp_valid_i,
  output logic                      [`CB_NB_TARG-1:0] targ_rsp_ready_o,
  output cluster_bus_pkg::init_rsp_t [`CB_NB_INIT-1:0] init_rsp_o,
  output logic                      [`CB_NB_INIT-1:0] init_rsp_valid_o,
  input  logic                      [`CB_NB_INIT-1:0] init_rsp_ready_i
);

  import cluster_bus_pkg::*;

  targ_sel_t [`CB_NB_INIT-1:0]                   targ_sel;
  logic      [`CB_NB_TARG-1:0][`CB_NB_INIT-1:0]  sel_col;
  logic      [`CB_NB_TARG-1:0][`CB_NB_INIT-1:0]  grant;

  for (genvar i = 0; i < `CB_NB_INIT; i++) begin : g_dec
    cluster_addr_decoder dec_i (
      .req_addr_i   ( init_req_i[i].addr ),
      .cluster_id_i ( cluster_id_i       ),
      .targ_sel_o   ( targ_sel[i]        )
    );
  end

  // Each arbiter sees one column of the decoder outputs, and an initiator
  // is ready when any arbiter grants it
  always_comb begin
    init_ready_o = '0;
    for (int t = 0; t < `CB_NB_TARG; t++) begin
      for (int i = 0; i < `CB_NB_INIT; i++) begin
        sel_col[t][i]   = targ_sel[i][t];
        init_ready_o[i] = init_ready_o[i] | grant[t][i];
      end
    end
  end

  for (genvar t = 0; t < `CB_NB_TARG; t++) begin : g_arb
    cluster_bus_arbiter arb_i (
      .clk_i        ( clk_i           ),
      .arst_n_i     ( arst_n_i        ),
      .req_valid_i  ( init_valid_i    ),
      .req_i        ( init_req_i      ),
      .sel_i        ( sel_col[t]      ),
      .grant_o      ( grant[t]        ),
      .targ_req_o   ( targ_req_o[t]   ),
      .targ_valid_o ( targ_valid_o[t] ),
      .targ_ready_i ( targ_ready_i[t] )
    );
  end

  cluster_resp_router rsp_router_i (
    .rsp_valid_i  ( targ_rsp_valid_i ),
    .rsp_i        ( targ_rsp_i       ),
    .rsp_ready_o  ( targ_rsp_ready_o ),
    .init_rsp_o   ( init_rsp_o       ),
    .init_valid_o ( init_rsp_valid_o ),
    .init_ready_i ( init_rsp_ready_i )
  );

endmodule

`default_nettype wire

// File: design/cluster_resp_router.sv
/* Cluster bus response router
   Steers each target response to the initiator named by its ID prefix and
   strips that prefix, lowest target index first on a collision */

`default_nettype none

`include "cluster_bus_macros.svh"

module cluster_resp_router (
  input  logic                      [`CB_NB_TARG-1:0] rsp_valid_i,
  input  cluster_bus_pkg::targ_rsp_t [`CB_NB_TARG-1:0] rsp_i,
  output logic                      [`CB_NB_TARG-1:0] rsp_ready_o,
  output cluster_bus_pkg::init_rsp_t [`CB_NB_INIT-1:0] init_rsp_o,
  output logic                      [`CB_NB_INIT-1:0] init_valid_o,
  input  logic                      [`CB_NB_INIT-1:0] init_ready_i
);

  import cluster_bus_pkg::*;

  init_idx_t [`CB_NB_TARG-1:0] rsp_dest;

  // Initiator index sits in the top bits of the widened ID
  always_comb begin
    for (int t = 0; t < `CB_NB_TARG; t++) begin
      rsp_dest[t] = rsp_i[t].id_out[`CB_ID_OUT_W-1 -: `CB_INIT_IDX_W];
    end
  end

  always_comb begin
    init_rsp_o   = '0;
    init_valid_o = '0;
    rsp_ready_o  = '0;
    for (int i = 0; i < `CB_NB_INIT; i++) begin
      for (int t = 0; t < `CB_NB_TARG; t++) begin
        if (!init_valid_o[i] && rsp_valid_i[t] && (rsp_dest[t] == init_idx_t'(i))) begin
          init_valid_o[i]     = 1'b1;
          init_rsp_o[i].rdata = rsp_i[t].rdata;
          init_rsp_o[i].id_in = rsp_i[t].id_out[`CB_ID_IN_W-1:0];
          // Losing targets keep ready low and retry
          rsp_ready_o[t]      = init_ready_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/cluster_bus_arbiter.sv
/* Cluster bus target arbiter
   Round-robin choice among the initiators that address this target, with
   the initiator index appended above the ID and one output register */

`default_nettype none

`include "cluster_bus_macros.svh"

module cluster_bus_arbiter (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                      [`CB_NB_INIT-1:0] req_valid_i,
  input  cluster_bus_pkg::init_req_t [`CB_NB_INIT-1:0] req_i,
  input  logic                      [`CB_NB_INIT-1:0] sel_i,
  output logic                      [`CB_NB_INIT-1:0] grant_o,
  output cluster_bus_pkg::targ_req_t                  targ_req_o,
  output logic                                        targ_valid_o,
  input  logic                                        targ_ready_i
);

  import cluster_bus_pkg::*;

  arb_state_e              state_q;
  targ_req_t               req_q;
  init_idx_t               last_q;
  init_idx_t               grant_idx;
  logic [`CB_NB_INIT-1:0]  req_masked;
  logic                    any_req;
  logic                    can_accept;
  logic                    grant_valid;

  // Only requests decoded for this target take part
  assign req_masked = req_valid_i & sel_i;

  // The register takes a new request when empty or when its content leaves now
  assign can_accept  = (state_q == ARB_EMPTY) || targ_ready_i;
  assign grant_valid = any_req && can_accept;

  // Search starts one past the last winner and wraps around
  always_comb begin
    init_idx_t cand;
    cand      = '0;
    any_req   = 1'b0;
    grant_idx = '0;
    for (int k = 1; k <= `CB_NB_INIT; k++) begin
      cand = last_q + init_idx_t'(k);
      if (!any_req && req_masked[cand]) begin
        any_req   = 1'b1;
        grant_idx = cand;
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (grant_valid) begin
      grant_o[grant_idx] = 1'b1;
    end
  end

  // Pointer resets to the last index so initiator 0 wins first
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ARB_EMPTY;
      last_q  <= init_idx_t'(`CB_NB_INIT - 1);
    end else begin
      case (state_q)
        ARB_EMPTY: begin
          if (grant_valid) begin
            state_q <= ARB_FULL;
          end
        end
        ARB_FULL: begin
          if (targ_ready_i && !grant_valid) begin
            state_q <= ARB_EMPTY;
          end
        end
        default: state_q <= ARB_EMPTY;
      endcase
      if (grant_valid) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_valid) begin
      req_q.addr   <= req_i[grant_idx].addr;
      req_q.wdata  <= req_i[grant_idx].wdata;
      req_q.we     <= req_i[grant_idx].we;
      req_q.id_out <= {grant_idx, req_i[grant_idx].id_in};
    end
  end

  assign targ_req_o   = req_q;
  assign targ_valid_o = (state_q == ARB_FULL);

endmodule

`default_nettype wire

// File: design/cluster_addr_decoder.sv
/* Cluster address decoder
   Maps a request address to a one-hot target select, with the tcdm and
   periph windows moved by the cluster offset and ext as the default route */

`default_nettype none

`include "cluster_bus_macros.svh"

module cluster_addr_decoder (
  input  cluster_bus_pkg::addr_t       req_addr_i,
  input  cluster_bus_pkg::cluster_id_t cluster_id_i,
  output cluster_bus_pkg::targ_sel_t   targ_sel_o
);

  import cluster_bus_pkg::*;

  addr_t cluster_offset;
  addr_t tcdm_start;
  addr_t tcdm_end;
  addr_t periph_start;
  addr_t periph_end;
  logic  tcdm_hit;
  logic  periph_hit;

  // Each cluster owns a 4 MiB slot
  assign cluster_offset = addr_t'(cluster_id_i) << `CB_CLUSTER_SHIFT;

  assign tcdm_start   = addr_t'(`CB_TCDM_START) + cluster_offset;
  assign tcdm_end     = addr_t'(`CB_TCDM_END) + cluster_offset;
  assign periph_start = addr_t'(`CB_PERIPH_START) + cluster_offset;
  assign periph_end   = addr_t'(`CB_PERIPH_END) + cluster_offset;

  assign tcdm_hit   = (req_addr_i >= tcdm_start) && (req_addr_i <= tcdm_end);
  assign periph_hit = (req_addr_i >= periph_start) && (req_addr_i <= periph_end);

  always_comb begin
    targ_sel_o = '0;
    if (tcdm_hit) begin
      targ_sel_o[`CB_TARG_TCDM] = 1'b1;
    end else if (periph_hit) begin
      targ_sel_o[`CB_TARG_PERIPH] = 1'b1;
    end else begin
      targ_sel_o[`CB_TARG_EXT] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/cluster_bus_pkg.sv
/* Cluster bus types
   Vector types and the request and response payloads of the crossbar */

`default_nettype none

`include "cluster_bus_macros.svh"

package cluster_bus_pkg;

  typedef logic [`CB_ADDR_W-1:0]       addr_t;
  typedef logic [`CB_DATA_W-1:0]       data_t;
  typedef logic [`CB_ID_IN_W-1:0]      id_in_t;
  typedef logic [`CB_ID_OUT_W-1:0]     id_out_t;
  typedef logic [`CB_INIT_IDX_W-1:0]   init_idx_t;
  typedef logic [`CB_CLUSTER_ID_W-1:0] cluster_id_t;
  typedef logic [`CB_NB_TARG-1:0]      targ_sel_t;

  typedef struct packed {
    addr_t  addr;
    data_t  wdata;
    logic   we;
    id_in_t id_in;
  } init_req_t;

  // Same request once the initiator index sits above the ID
  typedef struct packed {
    addr_t   addr;
    data_t   wdata;
    logic    we;
    id_out_t id_out;
  } targ_req_t;

  typedef struct packed {
    data_t   rdata;
    id_out_t id_out;
  } targ_rsp_t;

  typedef struct packed {
    data_t  rdata;
    id_in_t id_in;
  } init_rsp_t;

  typedef enum logic {
    ARB_EMPTY,
    ARB_FULL
  } arb_state_e;

endpackage

`default_nettype wire

// File: design/cluster_bus_macros.svh
/* Cluster bus configuration
   Widths, port counts and the cluster address map of the crossbar */

`ifndef CLUSTER_BUS_MACROS_SVH
`define CLUSTER_BUS_MACROS_SVH

`define CB_ADDR_W        32
`define CB_DATA_W        32
`define CB_ID_IN_W       4
`define CB_NB_INIT       4
`define CB_NB_TARG       3
`define CB_INIT_IDX_W    2
`define CB_ID_OUT_W      (`CB_ID_IN_W + `CB_INIT_IDX_W)
`define CB_CLUSTER_ID_W  6
`define CB_CLUSTER_SHIFT 22

`define CB_TCDM_START    32'h1000_0000
`define CB_TCDM_END      32'h100F_FFFF
`define CB_PERIPH_START  32'h1020_0000
`define CB_PERIPH_END    32'h103F_FFFF

`define CB_TARG_TCDM     0
`define CB_TARG_PERIPH   1
`define CB_TARG_EXT      2

`endif
